// File: all.f
common/ctrlPkg.sv
decode/instrDecoder.sv
execute/ctrlSequencer.sv
result/ctrlWordGen.sv
logic/irqArbiter.sv
logic/controlUnit.sv
bench/controlUnit_sva.sv
bench/controlUnitTb.sv

// File: bench/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb import ctrlPkg::*; ();

    localparam int startDelay  = 40;
    localparam int numIrq      = 4;
    localparam int resetCycles = 5;
    localparam int fields      = 7;                 // hex words per vector line
    localparam int maxVec      = 40;
    localparam int maxCycles   = 16;                // longest instruction takes 3
    localparam int holdCycles  = 6;                 // how long a HLT stays presented

    logic              clk;
    logic              rstN;
    instrT             instr;
    flagsT             flags;
    logic [numIrq-1:0] irqReq;
    addrT              irqVec [numIrq];
    ctrlWordT          ctrlWord;
    addrT              irqVector;
    logic [numIrq-1:0] irqClr;
    logic              cpuReset;

    logic [15:0] vecMem [maxVec*fields];            // flat, fields words per vector
    int          numVec;

    controlUnit #(
        .startDelay (startDelay),
        .numIrq     (numIrq)
    ) dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .flags     (flags),
        .irqReq    (irqReq),
        .irqVec    (irqVec),
        .ctrlWord  (ctrlWord),
        .irqVector (irqVector),
        .irqClr    (irqClr),
        .cpuReset  (cpuReset)
    );

    always #4 clk = ~clk;                           // 8 ns period

    // **************************************************
    // reporting and compare tasks
    task automatic stopRun(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string what, input ctrlWordT got, input ctrlWordT exp,
                             input ctrlWordT care);
        logic [$bits(ctrlWordT)-1:0] diff;
        diff = (got ^ exp) & care;                  // only the fields under test
        if (diff != '0) begin
            stopRun($sformatf("FAIL %0t: %s got %h expected %h mask %h",
                              $time, what, got, exp, care));
        end
    endtask

    task automatic checkAddr(input string what, input addrT got, input addrT exp);
        if (got != exp) begin
            stopRun($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        if (got != exp) begin
            stopRun($sformatf("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic checkClr(input string what, input logic [numIrq-1:0] got,
                            input logic [numIrq-1:0] exp);
        if (got != exp) begin
            stopRun($sformatf("FAIL %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    // alu class from the reference opcodes, mode from the low bits or second nibble
    function automatic logic aluField(input instrT word, output logic [3:0] mode);
        logic immForm;
        logic regForm;
        logic oneReg;
        immForm = (word[3:0] >= 4'h1) && (word[3:0] <= 4'h7);
        regForm = (word[3:0] == 4'hA) && (word[7:4] >= 4'h1) && (word[7:4] <= 4'h9);
        oneReg  = (word[3:0] == 4'hF) && (word[7:4] >= 4'hA) && (word[11:8] == 4'h0);
        mode    = immForm ? {1'b0, word[2:0]} : word[7:4];
        return immForm || regForm || oneReg;
    endfunction

    // **************************************************
    // start-up hold after reset
    task automatic watchStartUp();
        ctrlWordT exp;
        ctrlWordT care;
        int       edges;
        int       pulses;
        int       pulseEdge;
        exp                  = '0;
        care                 = '0;
        care.regFile.writeEn = 1'b1;
        care.dMem.writeEn    = 1'b1;
        care.dMem.readEn     = 1'b1;
        care.status          = '1;
        exp.status.src       = irqDisable;          // interrupts held off
        exp.status.flagEn    = 1'b1;
        edges                = 0;
        pulses               = 0;
        pulseEdge            = -1;
        repeat (resetCycles) @(posedge clk);
        rstN   <= 1'b1;
        irqReq <= '1;                               // requests pending through start-up
        @(negedge clk);
        while (cpuReset && edges < startDelay + 10) begin
            checkWord("start-up word", ctrlWord, exp, care);
            checkClr("start-up irqClr", irqClr, '0);
            if (ctrlWord.fetch.pcWriteEn) begin
                pulses++;
                pulseEdge = edges;                  // should be the last start cycle
            end
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (cpuReset) begin
            stopRun("timeout: cpuReset never fell after reset was released");
        end
        checkCount("edges until cpuReset falls", edges, startDelay + 1);
        checkCount("start-up pcWriteEn pulses", pulses, 1);
        checkCount("edge of the start-up pulse", pulseEdge, startDelay);
    endtask

    // **************************************************
    // one instruction run from the vector file
    task automatic runVector(input int idx);
        int                base;
        instrT             word;
        int                expCycles;
        int                expAddr;
        int                expWrites;
        logic [numIrq-1:0] expClr;
        logic [numIrq-1:0] clrSeen;
        logic [3:0]        mode;
        int                cycles;
        int                writes;
        int                winner;
        logic              done;
        ctrlWordT          firstWord;
        ctrlWordT          exp;
        ctrlWordT          care;
        base      = idx * fields;
        word      = vecMem[base];
        expCycles = int'(vecMem[base+3]);
        expAddr   = int'(vecMem[base+4]);
        expWrites = int'(vecMem[base+5]);
        expClr    = vecMem[base+6][numIrq-1:0];
        if (word[3:0] >= 4'h1 && word[3:0] <= 4'h9) begin
            word[15:8] = 8'($urandom);              // immediate or port byte
        end
        cycles  = 0;
        writes  = 0;
        clrSeen = '0;
        done    = 1'b0;
        @(posedge clk);
        instr  <= word;
        flags  <= flagsT'(vecMem[base+1][3:0]);
        irqReq <= vecMem[base+2][numIrq-1:0];
        if (expCycles == 0) begin
            // halted, no fetch and no entry
            repeat (holdCycles) begin
                @(negedge clk);
                checkCount($sformatf("vector %0d pcWriteEn", idx),
                           int'(ctrlWord.fetch.pcWriteEn), 0);
                checkClr($sformatf("vector %0d irqClr", idx), irqClr, '0);
                if (ctrlWord.dMem.writeEn) begin
                    writes++;
                end
            end
            checkCount($sformatf("vector %0d dMem writes", idx), writes, expWrites);
        end else begin
            while (!done && cycles < maxCycles) begin
                @(negedge clk);
                cycles++;
                if (cycles == 1) begin
                    firstWord = ctrlWord;
                end
                if (ctrlWord.dMem.writeEn) begin
                    writes++;
                end
                clrSeen = clrSeen | irqClr;
                done    = ctrlWord.fetch.pcWriteEn; // last cycle of the instruction
            end
            if (!done) begin
                stopRun($sformatf("timeout: vector %0d never raised pcWriteEn", idx));
            end
            checkCount($sformatf("vector %0d cycles", idx), cycles, expCycles);
            checkCount($sformatf("vector %0d dMem writes", idx), writes, expWrites);
            checkClr($sformatf("vector %0d irqClr", idx), clrSeen, expClr);
            if (expCycles == 2 && expAddr == 0) begin
                // IN or pointer load, read first
                exp                  = '0;
                care                 = '0;
                care.dMem.readEn     = 1'b1;
                care.regFile.writeEn = 1'b1;
                care.fetch.pcWriteEn = 1'b1;
                exp.dMem.readEn      = 1'b1;
                checkWord($sformatf("vector %0d first cycle", idx), firstWord, exp, care);
            end
            exp                  = '0;
            care                 = '0;
            care.fetch           = '1;
            exp.fetch.iMemAddr   = iMemAddrE'(3'(expAddr));
            exp.fetch.iMemReadEn = 1'b1;
            exp.fetch.pcWriteEn  = 1'b1;
            if (expCycles == 2 && expAddr == 0) begin
                care.regFile.writeEn = 1'b1;        // load data written back
                care.dMem.readEn     = 1'b1;
                exp.regFile.writeEn  = 1'b1;
            end
            if (expCycles == 1 && expClr == '0 && aluField(word, mode)) begin
                care.regFile.writeEn = 1'b1;
                care.alu.mode        = '1;
                care.status.flagEn   = 1'b1;
                exp.regFile.writeEn  = 1'b1;
                exp.alu.mode         = mode;
                exp.status.flagEn    = !(word[3:0] == 4'h1 || word[7:0] == 8'h1A);  // LDI, MOV
            end
            checkWord($sformatf("vector %0d last cycle", idx), ctrlWord, exp, care);
            if (expClr != '0) begin
                winner = 0;
                for (int i = numIrq - 1; i >= 0; i--) begin
                    if (expClr[i]) begin
                        winner = i;
                    end
                end
                checkAddr($sformatf("vector %0d irqVector", idx), irqVector, irqVec[winner]);
            end
        end
    endtask

    initial begin
        void'($urandom(39625));                     // single seed for the run
        clk     = 1'b0;
        rstN    = 1'b0;
        instr   = '0;
        flags   = '0;
        irqReq  = '0;
        for (int i = 0; i < numIrq; i++) begin
            irqVec[i] = addrT'(16'h0100 + 16'h0040 * i);
        end
        $readmemh("bench/ctrlVectors.mem", vecMem);
        numVec = 0;
        while (numVec < maxVec && vecMem[numVec*fields+3] != 16'hFFFF) begin
            numVec++;                               // FFFF cycles marks the end
        end
        if (numVec == maxVec) begin
            stopRun("vector file has no end marker or could not be read");
        end
        watchStartUp();
        for (int v = 0; v < numVec; v++) begin
            runVector(v);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: bench/controlUnit_sva.sv
`timescale 1ns/1ns

module controlUnitSva import ctrlPkg::*; #(
    parameter int numIrq = 4
) (
    input logic              clk,
    input logic              rstN,
    input ctrlWordT          ctrlWord,
    input logic [numIrq-1:0] irqClr,
    input logic              cpuReset
);

    // at most one request cleared per cycle
    clrOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(irqClr))
        else $error("irqClr has more than one bit set");

    // data memory never reads and writes at once
    noReadWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrlWord.dMem.writeEn && ctrlWord.dMem.readEn))
        else $error("dMem writeEn and readEn high together");

    // start-up hold keeps every write off
    quietStart: assert property (@(posedge clk)
        cpuReset |-> !ctrlWord.dMem.writeEn && !ctrlWord.regFile.writeEn && irqClr == '0)
        else $error("write or irq clear while cpuReset is high");

endmodule

bind controlUnit controlUnitSva #(
    .numIrq (numIrq)
) sva0 (
    .clk      (clk),
    .rstN     (rstN),
    .ctrlWord (ctrlWord),
    .irqClr   (irqClr),
    .cpuReset (cpuReset)
);

// File: bench/ctrlVectors.mem
// instr flags(carry zero neg irqEn) irqReq cycles iMemAddr(enum) dMemWrites irqClr, in hex
// cycles 0 holds the word a fixed time and expects no fetch, cycles FFFF ends the list
2301 0 0 1 0 0 0
031A 0 0 1 0 0 0
045A 8 0 1 0 0 0
00BF 0 0 1 0 0 0
4208 0 0 2 0 0 0
5509 0 0 1 0 1 0
02CA 0 0 1 0 1 0
04EA 0 0 2 0 0 0
012E 0 0 1 6 0 0
212E 8 0 1 6 0 0
412E 8 0 1 0 0 0
612E 0 0 1 0 0 0
812E 0 0 1 6 0 0
A12E 2 0 1 6 0 0
C12E 2 0 1 0 0 0
E12E E 0 1 6 0 0
641F 4 0 1 4 0 0
801F 4 0 1 0 0 0
0E2F 0 0 2 3 0 0
2E2F 0 0 1 1 0 0
0E3F 0 0 2 3 2 0
6E3F 0 0 1 1 0 0
0E4F 0 0 3 5 0 0
AE4F 0 0 1 0 0 0
FFFF 1 3 0 0 0 0
1203 1 6 2 2 2 2
045A 1 C 2 2 2 4
1203 0 9 1 0 0 0
0000 0 0 FFFF 0 0 0

// File: common/ctrlPkg.sv
package ctrlPkg;

    localparam int dataW = 16;          // instruction and address width

    typedef logic [dataW-1:0] instrT;   // one fetched instruction word
    typedef logic [dataW-1:0] addrT;    // instruction address, isr vectors

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic irqEn;                    // global interrupt enable
    } flagsT;

    typedef enum logic [3:0] {
        aluImm, aluReg,                 // register alu forms
        ioXfer, ptrXfer,                // port and pointer transfers
        branch, jump, call, ret,        // flow control
        nopHalt,                        // dirBit picks HLT
        illegal
    } instrClassE;

    typedef enum logic [2:0] {
        part1, part2, part3,            // generic instruction parts
        jumpFetch, callFetch,           // address word cycles
        irqEntry,                       // second push of isr entry
        start                           // start-up hold
    } phaseE;

    typedef struct packed {
        instrClassE instrClass;
        logic [3:0] aluOp;              // alu mode or pointer opcode nibble
        logic [3:0] regSel;             // register file port B select
        logic       dirBit;             // out / store / reg form / halt
        logic       condMet;            // condition code holds
        logic       noIrq;              // HLT and RET run uninterrupted
    } decodedT;

    // in start, takeIrq marks the last cycle of the delay
    typedef struct packed {
        phaseE phase;
        logic  takeIrq;
    } stepT;

    // **************************************************
    // control word select encodings
    typedef enum logic [2:0] {
        pcNext, pcPlusOne, irqVector, instrWord, regPair, returnAddr, pcRelative
    } iMemAddrE;

    typedef enum logic [2:0] {
        aluOut, retHigh, retLow, curHigh, curLow
    } dMemDataE;

    typedef enum logic [1:0] {
        pointer, portImm, pointerPlusOne
    } dMemAddrE;

    typedef enum logic {
        aluFlags, irqDisable
    } statusSrcE;

    typedef struct packed {
        logic       src;                // 0 alu out, 1 dmem read data
        logic [3:0] outBSelect;
        logic       writeEn;
        logic       add;                // pointer update through adder
        logic       constSrc;           // 0 plus one, 1 minus one
    } regFileT;

    typedef struct packed {
        logic       srcBImm;            // operand B from 8-bit immediate
        logic [3:0] mode;
    } aluT;

    typedef struct packed {
        dMemDataE data;
        dMemAddrE addr;
        logic     writeEn;
        logic     readEn;
    } dMemT;

    typedef struct packed {
        statusSrcE src;
        logic      flagEn;
    } statusT;

    typedef struct packed {
        iMemAddrE iMemAddr;
        logic     iMemReadEn;
        logic     pcWriteEn;            // marks the last cycle
    } fetchT;

    typedef struct packed {
        regFileT regFile;
        aluT     alu;
        dMemT    dMem;
        statusT  status;
        fetchT   fetch;
    } ctrlWordT;

endpackage

// File: decode/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import ctrlPkg::*; (
    input  instrT   instr,
    input  flagsT   flags,
    output decodedT decoded
);
    logic [3:0] opLow;
    logic [3:0] opHigh;
    logic isNop, isHlt, isImm, isIo, isRegReg, isSingle;
    logic isPtr, isBr, isBrReg, isJmp, isCall, isRet;

    assign opLow  = instr[3:0];                 // primary opcode
    assign opHigh = instr[7:4];                 // sub-opcode nibble

    // **************************************************
    // opcode matching
    assign isNop    = (instr == 16'h0000);
    assign isHlt    = (instr == 16'hFFFF);
    assign isImm    = (opLow >= 4'h1) && (opLow <= 4'h7);
    assign isIo     = (opLow == 4'h8) || (opLow == 4'h9);
    assign isRegReg = (opLow == 4'hA) && (opHigh >= 4'h1) && (opHigh <= 4'h9);
    assign isPtr    = (opLow == 4'hA) && (opHigh >= 4'hC) && !instr[8];
    assign isBr     = (opLow == 4'hE);              // pc relative
    assign isSingle = (opLow == 4'hF) && (opHigh >= 4'hA) && (instr[11:8] == 4'h0);
    assign isBrReg  = (instr[8:0] == 9'h01F) && !instr[12];     // through reg pair
    assign isJmp    = (instr[12:0] == 13'h0E2F);
    assign isCall   = (instr[12:0] == 13'h0E3F);
    assign isRet    = (instr[12:0] == 13'h0E4F);

    always_comb begin
        decoded.instrClass = illegal;
        decoded.aluOp      = 4'd0;                  // pass A
        decoded.regSel     = {instr[11:9], 1'b0};   // pair base
        decoded.dirBit     = 1'b0;
        decoded.noIrq      = isHlt || isRet;
        if (isNop || isHlt) begin
            decoded.instrClass = nopHalt;
            decoded.dirBit     = isHlt;
        end else if (isImm) begin
            decoded.instrClass = aluImm;
            decoded.aluOp      = {1'b0, instr[2:0]};    // op in low bits
        end else if (isIo) begin
            decoded.instrClass = ioXfer;
            decoded.dirBit     = instr[0];          // OUT
        end else if (isRegReg || isSingle) begin
            decoded.instrClass = aluReg;
            decoded.aluOp      = opHigh;
            decoded.regSel     = instr[11:8];       // zero for single reg
        end else if (isPtr) begin
            decoded.instrClass = ptrXfer;
            decoded.aluOp      = opHigh;            // bit 0 picks decrement
            decoded.dirBit     = !instr[5];         // store
        end else if (isBr || isBrReg) begin
            decoded.instrClass = branch;
            decoded.dirBit     = instr[0];          // register form
        end else if (isJmp) begin
            decoded.instrClass = jump;
        end else if (isCall) begin
            decoded.instrClass = call;
        end else if (isRet) begin
            decoded.instrClass = ret;
        end
    end

    // **************************************************
    // condition code in the top three bits
    always_comb begin
        case (instr[15:13])
            3'd1:    decoded.condMet = flags.carry;
            3'd2:    decoded.condMet = !flags.carry;
            3'd3:    decoded.condMet = flags.zero;
            3'd4:    decoded.condMet = !flags.zero;
            3'd5:    decoded.condMet = flags.negative;
            3'd6:    decoded.condMet = !flags.negative;
            default: decoded.condMet = 1'b1;        // always
        endcase
    end

endmodule

// File: execute/ctrlSequencer.sv
`timescale 1ns/1ns

module ctrlSequencer import ctrlPkg::*; #(
    parameter int startDelay = 40
) (
    input  logic    clk,
    input  logic    rstN,
    input  decodedT decoded,
    input  logic    irqPending,
    input  logic    irqEnable,
    output stepT    step,
    output logic    irqAck,
    output logic    cpuReset
);
    phaseE      phase;
    phaseE      nextPhase;
    logic [5:0] delay;                              // start-up cycle count
    logic       delayDone;
    logic       takeIrq;

    // **************************************************
    // phase and delay registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= start;
            delay <= '0;
        end else begin
            phase <= nextPhase;
            delay <= (phase == start) ? delay + 6'd1 : 6'd0;  // counts only in start
        end
    end

    assign delayDone = (phase == start) && (delay == 6'(startDelay));
    // entry only between instructions
    assign takeIrq   = (phase == part1) && irqEnable && irqPending && !decoded.noIrq;

    assign step.phase   = phase;
    assign step.takeIrq = takeIrq || delayDone;     // delay end rides on takeIrq
    assign irqAck       = (phase == irqEntry);      // clear the winner
    assign cpuReset     = (phase == start);

    // **************************************************
    // next phase
    always_comb begin
        nextPhase = part1;
        case (phase)
            start: begin
                nextPhase = delayDone ? part1 : start;
            end
            part1: begin
                if (takeIrq) begin
                    nextPhase = irqEntry;
                end else begin
                    case (decoded.instrClass)
                        ioXfer, ptrXfer: begin
                            nextPhase = decoded.dirBit ? part1 : part2;     // IN / load
                        end
                        jump:    nextPhase = decoded.condMet ? jumpFetch : part1;
                        call:    nextPhase = decoded.condMet ? callFetch : part1;
                        ret:     nextPhase = decoded.condMet ? part2 : part1;
                        default: nextPhase = part1;     // HLT repeats here
                    endcase
                end
            end
            part2: begin
                nextPhase = (decoded.instrClass == ret) ? part3 : part1;   // second pop
            end
            part3, jumpFetch, callFetch, irqEntry: begin
                nextPhase = part1;
            end
            default: begin
                nextPhase = start;                  // unused code
            end
        endcase
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ns

module controlUnit import ctrlPkg::*; #(
    parameter int startDelay = 40,                  // start-up hold cycles
    parameter int numIrq     = 4
) (
    input  logic              clk,
    input  logic              rstN,
    input  instrT             instr,
    input  flagsT             flags,
    input  logic [numIrq-1:0] irqReq,
    input  addrT              irqVec [numIrq],
    output ctrlWordT          ctrlWord,
    output addrT              irqVector,
    output logic [numIrq-1:0] irqClr,
    output logic              cpuReset
);
    decodedT decoded;                               // current instruction
    stepT    step;
    logic    irqPending;
    logic    irqAck;

    // **************************************************
    // decode, sequence, control word, interrupts
    instrDecoder u0 (
        .instr   (instr),
        .flags   (flags),
        .decoded (decoded)
    );

    ctrlSequencer #(
        .startDelay (startDelay)
    ) u1 (
        .clk        (clk),
        .rstN       (rstN),
        .decoded    (decoded),
        .irqPending (irqPending),
        .irqEnable  (flags.irqEn),                  // global enable flag
        .step       (step),
        .irqAck     (irqAck),
        .cpuReset   (cpuReset)
    );

    ctrlWordGen u2 (
        .decoded  (decoded),
        .step     (step),
        .ctrlWord (ctrlWord)
    );

    irqArbiter #(
        .numIrq (numIrq)
    ) u3 (
        .irqReq     (irqReq),
        .irqVec     (irqVec),
        .irqAck     (irqAck),
        .irqVector  (irqVector),
        .irqPending (irqPending),
        .irqClr     (irqClr)
    );

endmodule

// File: logic/irqArbiter.sv
`timescale 1ns/1ns

module irqArbiter import ctrlPkg::*; #(
    parameter int numIrq = 4
) (
    input  logic [numIrq-1:0] irqReq,
    input  addrT              irqVec [numIrq],
    input  logic              irqAck,
    output addrT              irqVector,
    output logic              irqPending,
    output logic [numIrq-1:0] irqClr
);
    logic [numIrq-1:0] grant;                       // one-hot winner

    // **************************************************
    // lowest set bit wins
    assign grant      = irqReq & (~irqReq + 1'b1);
    assign irqPending = |irqReq;
    assign irqClr     = irqAck ? grant : '0;        // pulse during entry only

    // and-or mux on the one-hot grant
    always_comb begin
        irqVector = '0;                             // zero when idle
        for (int i = 0; i < numIrq; i++) begin
            irqVector = irqVector | (irqVec[i] & {dataW{grant[i]}});
        end
    end

endmodule

// File: result/ctrlWordGen.sv
`timescale 1ns/1ns

module ctrlWordGen import ctrlPkg::*; (
    input  decodedT  decoded,
    input  stepT     step,
    output ctrlWordT ctrlWord
);
    localparam logic [3:0] spSel = 4'b1110;     // stack pointer low reg

    logic firstPart;
    logic lastPart;

    assign firstPart = (step.phase == part1);
    assign lastPart  = (step.phase == part2);   // second cycle of IN / load

    always_comb begin
        // **************************************************
        // safe word, one-cycle no-op
        ctrlWord.regFile.src        = 1'b0;                 // alu out
        ctrlWord.regFile.outBSelect = decoded.regSel;
        ctrlWord.regFile.writeEn    = 1'b0;
        ctrlWord.regFile.add        = 1'b0;
        ctrlWord.regFile.constSrc   = 1'b0;                 // plus one
        ctrlWord.alu.srcBImm        = 1'b0;                 // port B
        ctrlWord.alu.mode           = 4'd0;                 // pass A
        ctrlWord.dMem.data          = aluOut;
        ctrlWord.dMem.addr          = pointer;
        ctrlWord.dMem.writeEn       = 1'b0;
        ctrlWord.dMem.readEn        = 1'b0;
        ctrlWord.status.src         = aluFlags;
        ctrlWord.status.flagEn      = 1'b0;
        ctrlWord.fetch.iMemAddr     = pcNext;
        ctrlWord.fetch.iMemReadEn   = 1'b1;
        ctrlWord.fetch.pcWriteEn    = 1'b1;

        case (step.phase)
            start: begin
                ctrlWord.status.src      = irqDisable;      // hold interrupts off
                ctrlWord.status.flagEn   = 1'b1;
                ctrlWord.fetch.pcWriteEn = step.takeIrq;    // first fetch
            end
            irqEntry, callFetch: begin
                ctrlWord.regFile.outBSelect = spSel;
                ctrlWord.regFile.add        = 1'b1;
                ctrlWord.regFile.constSrc   = 1'b1;         // SP--
                ctrlWord.dMem.writeEn       = 1'b1;         // high byte push
                if (step.phase == irqEntry) begin
                    ctrlWord.dMem.data      = curHigh;
                    ctrlWord.status.src     = irqDisable;
                    ctrlWord.status.flagEn  = 1'b1;
                    ctrlWord.fetch.iMemAddr = irqVector;
                end else begin
                    ctrlWord.dMem.data      = retHigh;
                    ctrlWord.fetch.iMemAddr = instrWord;    // call target
                end
            end
            jumpFetch: begin
                ctrlWord.fetch.iMemAddr = instrWord;        // jump target
            end
            default: begin
                if (step.takeIrq) begin
                    // interrupt entry, first push
                    ctrlWord.regFile.outBSelect = spSel;
                    ctrlWord.regFile.add        = 1'b1;
                    ctrlWord.regFile.constSrc   = 1'b1;
                    ctrlWord.dMem.data          = curLow;
                    ctrlWord.dMem.writeEn       = 1'b1;
                    ctrlWord.status.src         = irqDisable;
                    ctrlWord.status.flagEn      = 1'b1;
                    ctrlWord.fetch.iMemAddr     = irqVector;
                    ctrlWord.fetch.iMemReadEn   = 1'b0;     // jump on next cycle
                    ctrlWord.fetch.pcWriteEn    = 1'b0;
                end else begin
                    case (decoded.instrClass)
                        aluImm, aluReg: begin
                            ctrlWord.regFile.writeEn = 1'b1;
                            ctrlWord.alu.srcBImm     = (decoded.instrClass == aluImm);
                            ctrlWord.alu.mode        = decoded.aluOp;
                            ctrlWord.status.flagEn   = (decoded.aluOp != 4'd1);    // LDI / MOV
                        end
                        ioXfer, ptrXfer: begin
                            ctrlWord.regFile.src      = 1'b1;       // dmem read data
                            ctrlWord.regFile.writeEn  = lastPart;
                            ctrlWord.dMem.writeEn     = decoded.dirBit;
                            ctrlWord.dMem.readEn      = !decoded.dirBit && firstPart;
                            ctrlWord.fetch.iMemReadEn = decoded.dirBit || lastPart;
                            ctrlWord.fetch.pcWriteEn  = decoded.dirBit || lastPart;
                            if (decoded.instrClass == ioXfer) begin
                                ctrlWord.dMem.addr = portImm;
                            end else begin
                                ctrlWord.regFile.add      = firstPart;      // pointer step
                                ctrlWord.regFile.constSrc = decoded.aluOp[0];
                            end
                        end
                        branch: begin
                            if (decoded.condMet) begin
                                ctrlWord.fetch.iMemAddr = decoded.dirBit ? regPair : pcRelative;
                            end
                        end
                        jump, call: begin
                            ctrlWord.fetch.iMemAddr  = decoded.condMet ? pcNext : pcPlusOne;
                            ctrlWord.fetch.pcWriteEn = !decoded.condMet;    // skip addr word
                            if (decoded.instrClass == call) begin
                                ctrlWord.regFile.outBSelect = spSel;
                                ctrlWord.regFile.add        = decoded.condMet;
                                ctrlWord.regFile.constSrc   = 1'b1;
                                ctrlWord.dMem.data          = retLow;   // low byte first
                                ctrlWord.dMem.writeEn       = decoded.condMet;
                            end
                        end
                        ret: begin
                            ctrlWord.regFile.outBSelect = spSel;
                            ctrlWord.regFile.add        = decoded.condMet && (step.phase != part3);
                            ctrlWord.dMem.addr          = pointerPlusOne;  // SP+1
                            ctrlWord.dMem.readEn        = decoded.condMet && (step.phase != part3);
                            ctrlWord.fetch.iMemAddr     = firstPart ? pcNext : returnAddr;
                            ctrlWord.fetch.iMemReadEn   = !decoded.condMet || (step.phase == part3);
                            ctrlWord.fetch.pcWriteEn    = !decoded.condMet || (step.phase == part3);
                        end
                        nopHalt: begin
                            ctrlWord.fetch.iMemReadEn = !decoded.dirBit;   // HLT stalls
                            ctrlWord.fetch.pcWriteEn  = !decoded.dirBit;
                        end
                        default: ;                              // illegal as NOP
                    endcase
                end
            end
        endcase
    end

endmodule

// File: run.sh
#!/bin/sh
# Verilator build and run of the control unit testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module controlUnitTb -f all.f -o controlUnitSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/controlUnitSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1
